//--- flist.f
+incdir+include
rtl/bpf_pkg.sv
rtl/bpf_alu.sv
rtl/bpf_scratch.sv
rtl/bpf_decode.sv
rtl/bpf_execute.sv
rtl/bpf_ret_unit.sv
rtl/bpf_filter.sv
test/bpf_filter_assert.sv
test/bpf_filter_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --top-module bpf_filter_tb \
    -f flist.f \
    -o sim_bpf_filter

./obj_dir/sim_bpf_filter | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0

//--- test/bpf_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module bpf_filter_tb;

    localparam int max_run_len = 16;   // Longest executed program, ALU test
    localparam int num_runs    = 115;
    localparam int cycle_limit = 4 * max_run_len * num_runs + 2000;

    logic                clk;
    logic                rst;
    logic                start;
    bpf_pkg::word_t      packet_len;
    bpf_pkg::code_addr_t inst_rd_addr;
    bpf_pkg::insn_t      inst_data = '0;
    bpf_pkg::byte_addr_t packet_rd_addr;
    bpf_pkg::word_t      packet_data = '0;
    logic                busy;
    logic                done;
    bpf_pkg::word_t      accept_len;

    bpf_pkg::insn_t imem [1024];
    logic [7:0]     pkt [4096];
    bpf_pkg::word_t ref_a;             // Reference machine state, lives across runs
    bpf_pkg::word_t ref_x;
    bpf_pkg::word_t ref_mem [16];
    logic [31:0]    lfsr_state;
    int             mismatches;
    int             failures;
    int             cycle_cnt;
    bpf_pkg::word_t len;
    bpf_pkg::word_t first_result;

    bpf_filter bpf_filter_inst (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .packet_len     (packet_len),
        .inst_rd_addr   (inst_rd_addr),
        .inst_data      (inst_data),
        .packet_rd_addr (packet_rd_addr),
        .packet_data    (packet_data),
        .busy           (busy),
        .done           (done),
        .accept_len     (accept_len)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        inst_data   <= imem[inst_rd_addr];
        packet_data <= {pkt[packet_rd_addr], pkt[packet_rd_addr + 12'd1],
                        pkt[packet_rd_addr + 12'd2], pkt[packet_rd_addr + 12'd3]};
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: no done within %0d cycles, errors so far %0d", cycle_limit,
                     mismatches + failures);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function bpf_pkg::word_t rand_bits(input int n);
        bpf_pkg::word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic bpf_pkg::insn_t mk_insn(input logic [7:0] op, input logic [7:0] jt,
                                               input logic [7:0] jf, input bpf_pkg::word_t k);
        return {8'h00, op, jt, jf, k};
    endfunction

    function automatic bpf_pkg::word_t word_at(input bpf_pkg::byte_addr_t a);
        return {pkt[a], pkt[a + 12'd1], pkt[a + 12'd2], pkt[a + 12'd3]}; // Big-endian
    endfunction

    // Classic BPF interpreter over imem and pkt
    function void ref_run(input bpf_pkg::word_t plen, output bpf_pkg::word_t res,
                          output int n);
        bpf_pkg::code_addr_t pc;
        bpf_pkg::insn_t      i;
        logic [7:0]          op;
        bpf_pkg::word_t      b;
        bpf_pkg::word_t      v;
        logic [33:0]         ea;
        logic                fin;
        logic                cond;
        pc  = '0;
        n   = 0;
        fin = 1'b0;
        res = '0;
        while (!fin && n < 1000) begin
            i  = imem[pc];
            op = i.opcode[7:0];
            n  = n + 1;
            pc = pc + 1'b1;
            b  = ((op & `BPF_SRC_MASK) == `BPF_SRC_X) ? ref_x : i.k;
            ea = {2'b00, i.k};
            if ((op & `BPF_MODE_MASK) == `BPF_MODE_IND) ea = ea + {2'b00, ref_x};
            case (op & `BPF_CLS_MASK)
                `BPF_CLS_LD: case (op & `BPF_MODE_MASK)
                    `BPF_MODE_IMM: ref_a = i.k;
                    `BPF_MODE_MEM: ref_a = ref_mem[i.k[3:0]];
                    `BPF_MODE_LEN: ref_a = plen;
                    default: begin
                        if (ea + 34'd4 > {2'b00, plen}) fin = 1'b1; // Reject
                        else ref_a = word_at(ea[11:0]);
                    end
                endcase
                `BPF_CLS_LDX: case (op & `BPF_MODE_MASK)
                    `BPF_MODE_IMM: ref_x = i.k;
                    `BPF_MODE_MEM: ref_x = ref_mem[i.k[3:0]];
                    `BPF_MODE_LEN: ref_x = plen;
                    default: begin
                        if (ea + 34'd4 > {2'b00, plen}) fin = 1'b1;
                        else ref_x = {26'd0, pkt[ea[11:0]][3:0], 2'b00};
                    end
                endcase
                `BPF_CLS_ST:  ref_mem[i.k[3:0]] = ref_a;
                `BPF_CLS_STX: ref_mem[i.k[3:0]] = ref_x;
                `BPF_CLS_ALU: case (op & `BPF_OP_MASK)
                    `BPF_OP_ADD: ref_a = ref_a + b;
                    `BPF_OP_SUB: ref_a = ref_a - b;
                    `BPF_OP_AND: ref_a = ref_a & b;
                    `BPF_OP_OR:  ref_a = ref_a | b;
                    `BPF_OP_LSH: ref_a = ref_a << b[4:0];
                    default:     ref_a = ref_a >> b[4:0];
                endcase
                `BPF_CLS_JMP: begin
                    case (op & `BPF_OP_MASK)
                        `BPF_OP_JEQ: cond = (ref_a == b);
                        `BPF_OP_JGT: cond = (ref_a > b);
                        `BPF_OP_JGE: cond = (ref_a >= b);
                        default:     cond = ((ref_a & b) != 0);
                    endcase
                    if ((op & `BPF_OP_MASK) == `BPF_OP_JA) pc = pc + i.k[9:0];
                    else pc = pc + (cond ? {2'b00, i.jt} : {2'b00, i.jf});
                end
                `BPF_CLS_RET: begin
                    v   = ((op & `BPF_RVAL_MASK) == `BPF_SRC_A) ? ref_a : i.k;
                    res = (v > plen) ? plen : v; // Clamp to packet
                    fin = 1'b1;
                end
                default: begin
                    if ((op & `BPF_OP_MASK) == `BPF_OP_TXA) ref_a = ref_x;
                    else ref_x = ref_a;
                end
            endcase
        end
    endfunction

    task automatic fill_packet(input int len_min, input int span);
        for (int i = 0; i < 1024; i++) pkt[i] = 8'(rand_bits(8));
        len = len_min + (rand_bits(10) % span);
    endtask

    // One start, wait for done, compare verdict and latency
    task automatic run_check(input bpf_pkg::word_t plen, input logic poke,
                             output bpf_pkg::word_t got);
        bpf_pkg::word_t exp;
        int             n;
        int             cycles;
        ref_run(plen, exp, n);
        @(negedge clk);
        packet_len = plen;
        start      = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        assert (busy) else begin
            failures++;
            $display("busy did not rise after start at %0t", $time);
        end
        while (!done) begin
            start = poke && (cycles == 5); // A start mid-run must be ignored
            @(negedge clk);
            cycles++;
            if (!done) assert (busy) else begin
                failures++;
                $display("busy dropped before done at %0t", $time);
            end
        end
        start = 1'b0;
        got   = accept_len;
        assert (accept_len == exp) else begin
            mismatches++;
            $display("MISMATCH %0t accept_len %0d, expected %0d", $time, accept_len, exp);
        end
        assert (cycles == 4 * n + 2) else begin
            mismatches++;
            $display("MISMATCH %0t done after %0d cycles, expected %0d", $time, cycles,
                     4 * n + 2);
        end
        assert (!busy) else begin
            failures++;
            $display("busy still high in the done cycle at %0t", $time);
        end
    endtask

    task automatic load_filter();
        imem[0] = mk_insn(`BPF_CLS_LD | `BPF_MODE_ABS, 0, 0, 12);
        imem[1] = mk_insn(`BPF_CLS_JMP | `BPF_OP_JGE, 0, 2, 32'h40000000);
        imem[2] = mk_insn(`BPF_CLS_JMP | `BPF_OP_JSET, 0, 1, 32'h00010000);
        imem[3] = mk_insn(`BPF_CLS_RET | `BPF_SRC_A, 0, 0, 0);
        imem[4] = mk_insn(`BPF_CLS_LD | `BPF_MODE_ABS, 0, 0, 0);
        imem[5] = mk_insn(`BPF_CLS_JMP | `BPF_OP_JGT, 0, 1, 32'h80000000);
        imem[6] = mk_insn(`BPF_CLS_RET | `BPF_SRC_K, 0, 0, 1000); // Often clamped
        imem[7] = mk_insn(`BPF_CLS_JMP | `BPF_OP_JEQ, 0, 1, 32'h12345678);
        imem[8] = mk_insn(`BPF_CLS_RET | `BPF_SRC_K, 0, 0, 0);
        imem[9] = mk_insn(`BPF_CLS_RET | `BPF_SRC_K, 0, 0, 64);
    endtask

    task automatic load_alu();
        logic [7:0] ops [6];
        ops = '{`BPF_OP_ADD, `BPF_OP_SUB, `BPF_OP_AND, `BPF_OP_OR, `BPF_OP_LSH, `BPF_OP_RSH};
        imem[0] = mk_insn(`BPF_CLS_JMP | `BPF_OP_JA, 0, 0, 1);
        imem[1] = mk_insn(`BPF_CLS_RET | `BPF_SRC_K, 0, 0, 0);  // Skipped by JA
        imem[2] = mk_insn(`BPF_CLS_LD | `BPF_MODE_IMM, 0, 0, rand_bits(32));
        imem[3] = mk_insn(`BPF_CLS_LDX | `BPF_MODE_IMM, 0, 0, rand_bits(32));
        for (int i = 0; i < 6; i++) begin
            imem[4 + 2 * i] = mk_insn(`BPF_CLS_ALU | ops[i] | `BPF_SRC_K, 0, 0, rand_bits(32));
            imem[5 + 2 * i] = mk_insn(`BPF_CLS_ALU | ops[i] | `BPF_SRC_X, 0, 0, 0);
        end
        imem[16] = mk_insn(`BPF_CLS_RET | `BPF_SRC_A, 0, 0, 0);
    endtask

    task automatic load_msh(input bpf_pkg::word_t k);
        imem[0] = mk_insn(`BPF_CLS_LDX | `BPF_MODE_MSH, 0, 0, k);
        imem[1] = mk_insn(`BPF_CLS_LD | `BPF_MODE_IND, 0, 0, k);
        imem[2] = mk_insn(`BPF_CLS_RET | `BPF_SRC_A, 0, 0, 0); // Whole loaded word
    endtask

    task automatic load_scratch();
        imem[0]  = mk_insn(`BPF_CLS_LD | `BPF_MODE_IMM, 0, 0, rand_bits(16));
        imem[1]  = mk_insn(`BPF_CLS_ST, 0, 0, 3);
        imem[2]  = mk_insn(`BPF_CLS_MISC | `BPF_OP_TAX, 0, 0, 0);
        imem[3]  = mk_insn(`BPF_CLS_LDX | `BPF_MODE_IMM, 0, 0, rand_bits(16));
        imem[4]  = mk_insn(`BPF_CLS_STX, 0, 0, 9);
        imem[5]  = mk_insn(`BPF_CLS_LD | `BPF_MODE_MEM, 0, 0, 9);
        imem[6]  = mk_insn(`BPF_CLS_LDX | `BPF_MODE_MEM, 0, 0, 3);
        imem[7]  = mk_insn(`BPF_CLS_ALU | `BPF_OP_SUB | `BPF_SRC_X, 0, 0, 0); // Order matters
        imem[8]  = mk_insn(`BPF_CLS_MISC | `BPF_OP_TAX, 0, 0, 0);
        imem[9]  = mk_insn(`BPF_CLS_LD | `BPF_MODE_LEN, 0, 0, 0);
        imem[10] = mk_insn(`BPF_CLS_MISC | `BPF_OP_TXA, 0, 0, 0);
        imem[11] = mk_insn(`BPF_CLS_RET | `BPF_SRC_A, 0, 0, 0);
    endtask

    task automatic load_oob(input bpf_pkg::word_t k, input logic use_msh);
        imem[0] = mk_insn(`BPF_CLS_LD | `BPF_MODE_IMM, 0, 0, 7);
        imem[1] = use_msh ? mk_insn(`BPF_CLS_LDX | `BPF_MODE_MSH, 0, 0, k)
                          : mk_insn(`BPF_CLS_LD | `BPF_MODE_ABS, 0, 0, k);
        imem[2] = mk_insn(`BPF_CLS_RET | `BPF_SRC_A, 0, 0, 0);
    endtask

    initial begin
        bpf_pkg::word_t got;
        rst        = 1'b1;
        start      = 1'b0;
        packet_len = '0;
        lfsr_state = 32'h1dffc86d;
        mismatches = 0;
        failures   = 0;
        cycle_cnt  = 0;
        ref_a      = '0;  // Reset values of A and X
        ref_x      = '0;
        for (int i = 0; i < 4096; i++) pkt[i] = '0;
        for (int i = 0; i < 1024; i++) imem[i] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        load_filter();
        repeat (50) begin
            fill_packet(8, 200);  // Short ones abort on the offset 12 load
            if (rand_bits(1) != 0) begin
                {pkt[0], pkt[1], pkt[2], pkt[3]} = 32'h12345678; // JEQ taken
            end
            run_check(len, 1'b0, got);
        end
        repeat (20) begin
            load_alu();
            run_check(32'hffffffff, 1'b0, got);
        end
        repeat (20) begin
            fill_packet(64, 900);
            load_msh(14);
            run_check(32'hffffffff, 1'b0, got);
        end
        repeat (20) begin
            load_scratch();
            run_check(32'hffffffff, 1'b0, got);
        end
        fill_packet(100, 1);
        load_oob(98, 1'b0);
        run_check(100, 1'b0, got);
        load_oob(96, 1'b0);       // Last word that fits
        run_check(100, 1'b0, got);
        load_oob(97, 1'b1);
        run_check(100, 1'b0, got);

        load_filter();
        fill_packet(16, 500);
        run_check(len, 1'b0, first_result);
        run_check(len, 1'b1, got);
        assert (got == first_result) else begin
            mismatches++;
            $display("MISMATCH %0t back-to-back result %0d, first %0d", $time, got,
                     first_result);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/bpf_filter_assert.sv
`timescale 1ns/1ps
`default_nettype none

module bpf_filter_assert (
    input wire logic           clk,
    input wire logic           rst,
    input wire logic           start,
    input wire logic           busy,
    input wire logic           done,
    input wire logic           pc_clear,
    input wire bpf_pkg::word_t accept_len,
    input wire bpf_pkg::word_t packet_len
);

    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Quiet right after reset
    reset_idle: assert property (@(posedge clk) rst |=> (!busy && !done))
        else $error("busy or done high after reset");

    busy_ends: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
        else $error("busy fell without done");

    done_not_busy: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else $error("busy still high with done");

    verdict_clamped: assert property (@(posedge clk) disable iff (rst)
        done |-> (accept_len <= packet_len))
        else $error("accept_len larger than packet_len");

    start_ignored: assert property (@(posedge clk) disable iff (rst)
        (start && busy) |=> !pc_clear)
        else $error("start during a run restarted the engine");

endmodule

bind bpf_filter bpf_filter_assert bpf_filter_assert_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .pc_clear   (pc_clear),
    .accept_len (accept_len),
    .packet_len (packet_len)
);

`default_nettype wire

//--- rtl/bpf_filter.sv
`timescale 1ns/1ps
`default_nettype none

module bpf_filter (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            start,
    input  wire bpf_pkg::word_t  packet_len,
    output bpf_pkg::code_addr_t  inst_rd_addr,
    input  wire bpf_pkg::insn_t  inst_data,
    output bpf_pkg::byte_addr_t  packet_rd_addr,
    input  wire bpf_pkg::word_t  packet_data,
    output logic                 busy,
    output logic                 done,
    output bpf_pkg::word_t       accept_len
);

    bpf_pkg::ctrl_t  ctrl;
    bpf_pkg::insn_t  insn;      // Latched instruction
    bpf_pkg::flags_t flags;
    bpf_pkg::word_t  acc;
    logic            abort;     // Out of bounds packet load
    logic            pc_clear;
    logic            ret_strobe;
    logic            ret_from_a;

    bpf_decode bpf_decode_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .inst_data  (inst_data),
        .flags      (flags),
        .abort      (abort),
        .ctrl       (ctrl),
        .insn       (insn),
        .pc_clear   (pc_clear),
        .ret_strobe (ret_strobe),
        .ret_from_a (ret_from_a),
        .busy       (busy)
    );

    bpf_execute bpf_execute_inst (
        .clk            (clk),
        .rst            (rst),
        .pc_clear       (pc_clear),
        .ctrl           (ctrl),
        .insn           (insn),
        .packet_len     (packet_len),
        .packet_data    (packet_data),
        .inst_rd_addr   (inst_rd_addr),
        .packet_rd_addr (packet_rd_addr),
        .flags          (flags),
        .acc            (acc),
        .abort          (abort)
    );

    bpf_ret_unit bpf_ret_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .ret_strobe (ret_strobe),
        .ret_from_a (ret_from_a),
        .abort      (abort),
        .k          (insn.k),
        .acc        (acc),
        .packet_len (packet_len),
        .done       (done),
        .accept_len (accept_len)
    );

endmodule

`default_nettype wire

//--- rtl/bpf_ret_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bpf_ret_unit (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           ret_strobe,
    input  wire logic           ret_from_a,
    input  wire logic           abort,
    input  wire bpf_pkg::word_t k,
    input  wire bpf_pkg::word_t acc,
    input  wire bpf_pkg::word_t packet_len,
    output logic                done,
    output bpf_pkg::word_t      accept_len
);

    bpf_pkg::word_t ret_val;
    bpf_pkg::word_t verdict;

    assign ret_val = ret_from_a ? acc : k;
    // Never accept more than the packet holds
    assign verdict = abort                  ? '0 :
                     (ret_val > packet_len) ? packet_len : ret_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            done       <= 1'b0;
            accept_len <= '0;
        end else begin
            done <= ret_strobe | abort;                        // Single cycle, write is
            if (ret_strobe || abort) accept_len <= verdict;    // Held until next run ends
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpf_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module bpf_execute (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            pc_clear,
    input  wire bpf_pkg::ctrl_t  ctrl,
    input  wire bpf_pkg::insn_t  insn,
    input  wire bpf_pkg::word_t  packet_len,
    input  wire bpf_pkg::word_t  packet_data,
    output bpf_pkg::code_addr_t  inst_rd_addr,
    output bpf_pkg::byte_addr_t  packet_rd_addr,
    output bpf_pkg::flags_t      flags,
    output bpf_pkg::word_t       acc,
    output logic                 abort
);

    localparam int scratch_aw = $clog2(`BPF_SCRATCH_WORDS);

    bpf_pkg::word_t      a_q;
    bpf_pkg::word_t      x_q;
    bpf_pkg::code_addr_t pc_q;
    bpf_pkg::code_addr_t pc_inc;        // Next instruction
    bpf_pkg::word_t      alu_b;
    bpf_pkg::word_t      alu_result;
    bpf_pkg::word_t      scratch_wdata;
    bpf_pkg::word_t      scratch_rdata;
    logic [32:0]         pkt_base;      // Unwrapped byte address
    logic                oob;

    assign inst_rd_addr = pc_q;
    assign acc          = a_q;
    assign pc_inc       = pc_q + 1'b1;

    // Packet address, k or X + k
    assign pkt_base = (ctrl.addr_sel == bpf_pkg::addr_ind) ? {1'b0, x_q} + {1'b0, insn.k}
                                                           : {1'b0, insn.k};
    assign packet_rd_addr = pkt_base[`BPF_BYTE_ADDR_WIDTH-1:0];
    assign oob   = ({1'b0, pkt_base} + 34'd4) > {2'b00, packet_len}; // Word must fit in packet
    assign abort = ctrl.pkt_load & oob;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_q <= '0;
        end else if (ctrl.a_en && !abort) begin
            case (ctrl.a_sel)
                bpf_pkg::a_imm:     a_q <= insn.k;
                bpf_pkg::a_packet:  a_q <= packet_data;   // Big-endian word at address
                bpf_pkg::a_scratch: a_q <= scratch_rdata;
                bpf_pkg::a_len:     a_q <= packet_len;
                bpf_pkg::a_alu:     a_q <= alu_result;
                bpf_pkg::a_x:       a_q <= x_q;           // TXA
                default:            a_q <= a_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= '0;
        end else if (ctrl.x_en && !abort) begin
            case (ctrl.x_sel)
                bpf_pkg::x_imm:     x_q <= insn.k;
                bpf_pkg::x_scratch: x_q <= scratch_rdata;
                bpf_pkg::x_len:     x_q <= packet_len;
                bpf_pkg::x_msh:     x_q <= {26'd0, packet_data[27:24], 2'b00}; // 4*(P[k]&0xf)
                bpf_pkg::x_a:       x_q <= a_q;           // TAX
                default:            x_q <= x_q;
            endcase
        end
    end

    // Offsets count from the following instruction
    always_ff @(posedge clk) begin
        if (rst || pc_clear) begin
            pc_q <= '0;
        end else if (ctrl.pc_en) begin
            case (ctrl.pc_sel)
                bpf_pkg::pc_plus_1:  pc_q <= pc_inc;
                bpf_pkg::pc_plus_jt: pc_q <= pc_inc + bpf_pkg::code_addr_t'(insn.jt);
                bpf_pkg::pc_plus_jf: pc_q <= pc_inc + bpf_pkg::code_addr_t'(insn.jf);
                bpf_pkg::pc_plus_k:  pc_q <= pc_inc + bpf_pkg::code_addr_t'(insn.k); // JA
                default:             pc_q <= pc_inc;
            endcase
        end
    end

    assign alu_b = ctrl.b_is_x ? x_q : insn.k;

    bpf_alu bpf_alu_inst (
        .clk    (clk),
        .a      (a_q),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .flags  (flags)
    );

    assign scratch_wdata = ctrl.scratch_from_x ? x_q : a_q; // STX or ST

    bpf_scratch bpf_scratch_inst (
        .clk   (clk),
        .addr  (insn.k[scratch_aw-1:0]),
        .wdata (scratch_wdata),
        .wr_en (ctrl.scratch_wr),
        .rdata (scratch_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/bpf_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module bpf_decode (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           start,
    input  wire bpf_pkg::insn_t inst_data,
    input  wire bpf_pkg::flags_t flags,
    input  wire logic           abort,
    output bpf_pkg::ctrl_t      ctrl,
    output bpf_pkg::insn_t      insn,
    output logic                pc_clear,
    output logic                ret_strobe,
    output logic                ret_from_a,
    output logic                busy
);

    bpf_pkg::ctrl_state_e state, state_nxt;
    bpf_pkg::insn_t       insn_q;
    logic [7:0]           opc;       // Classic BPF code byte
    logic                 in_write;
    logic                 is_ret;

    assign opc      = insn_q.opcode[7:0];
    assign in_write = (state == bpf_pkg::st_write);
    assign is_ret   = ((opc & `BPF_CLS_MASK) == `BPF_CLS_RET);

    assign ret_strobe = in_write & is_ret;
    assign ret_from_a = ret_strobe & ((opc & `BPF_RVAL_MASK) == `BPF_SRC_A);
    assign busy       = (state != bpf_pkg::st_idle) | pc_clear; // Low again with done
    assign insn       = insn_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= bpf_pkg::st_idle;
            pc_clear <= 1'b0;
        end else begin
            state    <= state_nxt;
            pc_clear <= (state == bpf_pkg::st_idle) & start & ~pc_clear; // Start ignored once launched
        end
    end

    always_comb begin
        case (state)
            bpf_pkg::st_idle:   state_nxt = pc_clear ? bpf_pkg::st_fetch : bpf_pkg::st_idle;
            bpf_pkg::st_fetch:  state_nxt = bpf_pkg::st_decode;
            bpf_pkg::st_decode: state_nxt = bpf_pkg::st_exec;
            bpf_pkg::st_exec:   state_nxt = bpf_pkg::st_write;
            bpf_pkg::st_write:  state_nxt = (is_ret | abort) ? bpf_pkg::st_idle : bpf_pkg::st_fetch;
            default:            state_nxt = bpf_pkg::st_idle;
        endcase
    end

    // Memory answered the fetch address during decode
    always_ff @(posedge clk) begin
        if (state == bpf_pkg::st_decode) insn_q <= inst_data;
    end

    always_comb begin
        ctrl        = '0;
        ctrl.pc_sel = bpf_pkg::pc_plus_1;
        ctrl.pc_en  = 1'b1;
        ctrl.b_is_x = ((opc & `BPF_SRC_MASK) == `BPF_SRC_X);
        case (opc & `BPF_CLS_MASK)
            `BPF_CLS_LD: begin
                ctrl.a_en = 1'b1;
                case (opc & `BPF_MODE_MASK)
                    `BPF_MODE_IMM: ctrl.a_sel = bpf_pkg::a_imm;
                    `BPF_MODE_ABS: begin
                        ctrl.a_sel    = bpf_pkg::a_packet;
                        ctrl.pkt_load = 1'b1;
                    end
                    `BPF_MODE_IND: begin
                        ctrl.a_sel    = bpf_pkg::a_packet;
                        ctrl.addr_sel = bpf_pkg::addr_ind; // X + k
                        ctrl.pkt_load = 1'b1;
                    end
                    `BPF_MODE_MEM: ctrl.a_sel = bpf_pkg::a_scratch;
                    `BPF_MODE_LEN: ctrl.a_sel = bpf_pkg::a_len;
                    default:       ctrl.a_en  = 1'b0;
                endcase
            end
            `BPF_CLS_LDX: begin
                ctrl.x_en = 1'b1;
                case (opc & `BPF_MODE_MASK)
                    `BPF_MODE_IMM: ctrl.x_sel = bpf_pkg::x_imm;
                    `BPF_MODE_MEM: ctrl.x_sel = bpf_pkg::x_scratch;
                    `BPF_MODE_LEN: ctrl.x_sel = bpf_pkg::x_len;
                    `BPF_MODE_MSH: begin
                        ctrl.x_sel    = bpf_pkg::x_msh;
                        ctrl.pkt_load = 1'b1; // Same 4 byte window check as word loads
                    end
                    default:       ctrl.x_en  = 1'b0;
                endcase
            end
            `BPF_CLS_ST:  ctrl.scratch_wr = 1'b1;
            `BPF_CLS_STX: begin
                ctrl.scratch_wr     = 1'b1;
                ctrl.scratch_from_x = 1'b1;
            end
            `BPF_CLS_ALU: begin
                ctrl.a_sel = bpf_pkg::a_alu;
                ctrl.a_en  = 1'b1;
                case (opc & `BPF_OP_MASK)
                    `BPF_OP_ADD: ctrl.alu_op = bpf_pkg::alu_add;
                    `BPF_OP_SUB: ctrl.alu_op = bpf_pkg::alu_sub;
                    `BPF_OP_AND: ctrl.alu_op = bpf_pkg::alu_and;
                    `BPF_OP_OR:  ctrl.alu_op = bpf_pkg::alu_or;
                    `BPF_OP_LSH: ctrl.alu_op = bpf_pkg::alu_lsh;
                    `BPF_OP_RSH: ctrl.alu_op = bpf_pkg::alu_rsh;
                    default:     ctrl.a_en   = 1'b0; // mul, div, neg not built
                endcase
            end
            `BPF_CLS_JMP: begin
                ctrl.alu_op = bpf_pkg::alu_cmp;
                // Flags registered in exec
                case (opc & `BPF_OP_MASK)
                    `BPF_OP_JA:   ctrl.pc_sel = bpf_pkg::pc_plus_k;
                    `BPF_OP_JEQ:  ctrl.pc_sel = flags.eq  ? bpf_pkg::pc_plus_jt : bpf_pkg::pc_plus_jf;
                    `BPF_OP_JGT:  ctrl.pc_sel = flags.gt  ? bpf_pkg::pc_plus_jt : bpf_pkg::pc_plus_jf;
                    `BPF_OP_JGE:  ctrl.pc_sel = flags.ge  ? bpf_pkg::pc_plus_jt : bpf_pkg::pc_plus_jf;
                    `BPF_OP_JSET: ctrl.pc_sel = flags.set ? bpf_pkg::pc_plus_jt : bpf_pkg::pc_plus_jf;
                    default:      ctrl.pc_sel = bpf_pkg::pc_plus_1;
                endcase
            end
            `BPF_CLS_MISC: begin
                if ((opc & `BPF_OP_MASK) == `BPF_OP_TXA) begin
                    ctrl.a_sel = bpf_pkg::a_x;
                    ctrl.a_en  = 1'b1;
                end else if ((opc & `BPF_OP_MASK) == `BPF_OP_TAX) begin
                    ctrl.x_sel = bpf_pkg::x_a;
                    ctrl.x_en  = 1'b1;
                end
            end
            default: ctrl.pc_en = 1'b0; // RET, run ends
        endcase

        // Everything that changes state happens in write
        ctrl.a_en       = ctrl.a_en & in_write;
        ctrl.x_en       = ctrl.x_en & in_write;
        ctrl.pc_en      = ctrl.pc_en & in_write;
        ctrl.scratch_wr = ctrl.scratch_wr & in_write;
        ctrl.pkt_load   = ctrl.pkt_load & in_write;
    end

endmodule

`default_nettype wire

//--- rtl/bpf_scratch.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module bpf_scratch (
    input  wire logic                                    clk,
    input  wire logic [$clog2(`BPF_SCRATCH_WORDS)-1:0]   addr,
    input  wire bpf_pkg::word_t                          wdata,
    input  wire logic                                    wr_en,
    output bpf_pkg::word_t                               rdata
);

    bpf_pkg::word_t mem [`BPF_SCRATCH_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) mem[addr] <= wdata;
        rdata <= mem[addr];  // Address from exec, data in write
    end

endmodule

`default_nettype wire

//--- rtl/bpf_alu.sv
`timescale 1ns/1ps
`default_nettype none

module bpf_alu (
    input  wire logic             clk,
    input  wire bpf_pkg::word_t   a,
    input  wire bpf_pkg::word_t   b,
    input  wire bpf_pkg::alu_op_e op,
    output bpf_pkg::word_t        result,
    output bpf_pkg::flags_t       flags
);

    bpf_pkg::word_t result_nxt;
    logic [4:0]     shamt;

    assign shamt = b[4:0]; // Shift count mod 32

    always_comb begin
        case (op)
            bpf_pkg::alu_add: result_nxt = a + b;   // Wraps at 32 bits
            bpf_pkg::alu_sub: result_nxt = a - b;
            bpf_pkg::alu_and: result_nxt = a & b;
            bpf_pkg::alu_or:  result_nxt = a | b;
            bpf_pkg::alu_lsh: result_nxt = a << shamt;
            bpf_pkg::alu_rsh: result_nxt = a >> shamt; // Logical
            bpf_pkg::alu_cmp: result_nxt = a;       // Jumps only look at flags
            default:          result_nxt = a;
        endcase
    end

    // Flags track every cycle, unsigned compares
    always_ff @(posedge clk) begin
        result    <= result_nxt;
        flags.eq  <= (a == b);
        flags.gt  <= (a > b);
        flags.ge  <= (a >= b);
        flags.set <= |(a & b);
    end

endmodule

`default_nettype wire

//--- rtl/bpf_pkg.sv
`default_nettype none

`include "bpf_params.svh"

package bpf_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`BPF_CODE_ADDR_WIDTH-1:0] code_addr_t;
    typedef logic [`BPF_BYTE_ADDR_WIDTH-1:0] byte_addr_t;

    // Same layout as struct sock_filter
    typedef struct packed {
        logic [15:0] opcode;
        logic [7:0]  jt;
        logic [7:0]  jf;
        word_t       k;
    } insn_t;

    typedef enum logic [2:0] {a_imm, a_packet, a_scratch, a_len, a_alu, a_x} a_sel_e;
    typedef enum logic [2:0] {x_imm, x_scratch, x_len, x_msh, x_a} x_sel_e;
    typedef enum logic [1:0] {pc_plus_1, pc_plus_jt, pc_plus_jf, pc_plus_k} pc_sel_e;
    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_lsh, alu_rsh, alu_cmp
    } alu_op_e;
    typedef enum logic {addr_abs, addr_ind} addr_sel_e;

    typedef enum logic [2:0] {st_idle, st_fetch, st_decode, st_exec, st_write} ctrl_state_e;

    // Compare results of A against B
    typedef struct packed {
        logic eq;
        logic gt;
        logic ge;
        logic set;
    } flags_t;

    typedef struct packed {
        a_sel_e    a_sel;
        logic      a_en;      // Write state only
        x_sel_e    x_sel;
        logic      x_en;
        pc_sel_e   pc_sel;
        logic      pc_en;
        logic      b_is_x;    // ALU operand B is X, else k
        alu_op_e   alu_op;
        logic      scratch_wr;
        logic      scratch_from_x;
        addr_sel_e addr_sel;  // Valid from exec on
        logic      pkt_load;  // Bounds check armed
    } ctrl_t;

endpackage

`default_nettype wire

//--- include/bpf_params.svh
`ifndef BPF_PARAMS_SVH
`define BPF_PARAMS_SVH

// Address widths
`define BPF_CODE_ADDR_WIDTH 10  // 1K instructions
`define BPF_BYTE_ADDR_WIDTH 12  // 4 KB packet buffer
`define BPF_SCRATCH_WORDS   16  // M[0..15]

// Field masks on the low opcode byte
`define BPF_CLS_MASK  8'h07
`define BPF_MODE_MASK 8'he0
`define BPF_OP_MASK   8'hf0
`define BPF_SRC_MASK  8'h08
`define BPF_RVAL_MASK 8'h18  // RET operand field

// Instruction classes
`define BPF_CLS_LD   8'h00
`define BPF_CLS_LDX  8'h01
`define BPF_CLS_ST   8'h02
`define BPF_CLS_STX  8'h03
`define BPF_CLS_ALU  8'h04
`define BPF_CLS_JMP  8'h05
`define BPF_CLS_RET  8'h06
`define BPF_CLS_MISC 8'h07

// Addressing modes, word size only
`define BPF_MODE_IMM 8'h00
`define BPF_MODE_ABS 8'h20
`define BPF_MODE_IND 8'h40
`define BPF_MODE_MEM 8'h60
`define BPF_MODE_LEN 8'h80
`define BPF_MODE_MSH 8'ha0

// Operand source
`define BPF_SRC_K 8'h00
`define BPF_SRC_X 8'h08
`define BPF_SRC_A 8'h10  // RET A

// ALU ops
`define BPF_OP_ADD 8'h00
`define BPF_OP_SUB 8'h10
`define BPF_OP_OR  8'h40
`define BPF_OP_AND 8'h50
`define BPF_OP_LSH 8'h60
`define BPF_OP_RSH 8'h70

// Jump ops
`define BPF_OP_JA   8'h00
`define BPF_OP_JEQ  8'h10
`define BPF_OP_JGT  8'h20
`define BPF_OP_JGE  8'h30
`define BPF_OP_JSET 8'h40

// Misc ops
`define BPF_OP_TAX 8'h00
`define BPF_OP_TXA 8'h80

`endif
